// ==== hdl/udp_tx_cfg.svh ====
// Build constants for the UDP transmit mux
// Source count, payload width and host register map
`ifndef UDP_TX_CFG_SVH
`define UDP_TX_CFG_SVH

`define UDP_S_COUNT     2
`define UDP_SEL_W       1
`define UDP_DATA_W      8
`define UDP_KEEP_W      (`UDP_DATA_W / 8)    // One keep bit per byte

`define UDP_REG_AW      2
`define UDP_REG_DW      16
`define UDP_REG_CTRL    0                    // Enable in bit 0 and select in bit 1
`define UDP_REG_FRAMES  1                    // Read only

`endif

// ==== hdl/udp_tx_pkg.sv ====
// Header field types for the UDP transmit path
`include "udp_tx_cfg.svh"

package udp_tx_pkg;

    // IP fields carried with each UDP header
    typedef logic [31:0] ip_addr_t;
    typedef logic [5:0]  ip_dscp_t;
    typedef logic [1:0]  ip_ecn_t;
    typedef logic [7:0]  ip_ttl_t;

    // UDP fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;             // Length and checksum

    // Index of a transmit source
    typedef logic [`UDP_SEL_W-1:0] src_sel_t;

endpackage

// ==== hdl/udp_tx_regs.sv ====
// Host register block for the UDP transmit mux
// Control word with enable and select, plus the forwarded-frame counter
`timescale 1ns/1ns
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx_regs
    import udp_tx_pkg::*;
(
    input  var logic                     clk,
    input  var logic                     arst_n,

    input  var logic                     wr_en,
    input  var logic [`UDP_REG_AW-1:0]   wr_addr,
    input  var logic [`UDP_REG_DW-1:0]   wr_data,
    input  var logic                     rd_en,
    input  var logic [`UDP_REG_AW-1:0]   rd_addr,
    input  var logic                     frame_done,

    output var logic [`UDP_REG_DW-1:0]   rd_data,
    output var logic                     rd_valid,
    output var logic                     enable,
    output var src_sel_t                 select
);

    localparam logic [`UDP_REG_AW-1:0] ADDR_CTRL   = `UDP_REG_CTRL;
    localparam logic [`UDP_REG_AW-1:0] ADDR_FRAMES = `UDP_REG_FRAMES;

    logic [`UDP_REG_DW-1:0] frame_cnt;
    logic [`UDP_REG_DW-1:0] ctrl_word;

    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[0]               = enable;
        ctrl_word[1 +: `UDP_SEL_W] = select;
    end

    // Control register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable <= 1'b0;
            select <= '0;
        end else if (wr_en && wr_addr == ADDR_CTRL) begin
            enable <= wr_data[0];
            select <= wr_data[1 +: `UDP_SEL_W];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;          // Wraps at full width
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (rd_addr)
                ADDR_CTRL:   rd_data <= ctrl_word;
                ADDR_FRAMES: rd_data <= frame_cnt;
                default:     rd_data <= '0;     // Unmapped addresses
            endcase
        end
    end

    // Read response comes back exactly one cycle after the strobe
    rd_valid_follows_rd_en: assert property (
        @(posedge clk) disable iff (!arst_n)
        1'b1 |=> rd_valid == $past(rd_en)
    );

endmodule

`default_nettype wire

// ==== hdl/udp_mux.sv ====
// UDP header and payload multiplexer
// Source is locked from header acceptance until its tlast beat
`timescale 1ns/1ns
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_mux
    import udp_tx_pkg::*;
(
    input  var logic                                       clk,
    input  var logic                                       arst_n,
    input  var logic                                       enable,
    input  var src_sel_t                                   select,

    input  var logic      [`UDP_S_COUNT-1:0]               s_hdr_valid,
    output var logic      [`UDP_S_COUNT-1:0]               s_hdr_ready,
    input  var ip_dscp_t  [`UDP_S_COUNT-1:0]               s_ip_dscp,
    input  var ip_ecn_t   [`UDP_S_COUNT-1:0]               s_ip_ecn,
    input  var ip_ttl_t   [`UDP_S_COUNT-1:0]               s_ip_ttl,
    input  var ip_addr_t  [`UDP_S_COUNT-1:0]               s_ip_source_ip,
    input  var ip_addr_t  [`UDP_S_COUNT-1:0]               s_ip_dest_ip,
    input  var udp_port_t [`UDP_S_COUNT-1:0]               s_source_port,
    input  var udp_port_t [`UDP_S_COUNT-1:0]               s_dest_port,
    input  var udp_len_t  [`UDP_S_COUNT-1:0]               s_length,
    input  var udp_len_t  [`UDP_S_COUNT-1:0]               s_checksum,

    input  var logic [`UDP_S_COUNT-1:0][`UDP_DATA_W-1:0]   s_tdata,
    input  var logic [`UDP_S_COUNT-1:0][`UDP_KEEP_W-1:0]   s_tkeep,
    input  var logic [`UDP_S_COUNT-1:0]                    s_tvalid,
    output var logic [`UDP_S_COUNT-1:0]                    s_tready,
    input  var logic [`UDP_S_COUNT-1:0]                    s_tlast,

    output var logic                                       m_hdr_valid,
    input  var logic                                       m_hdr_ready,
    output var ip_dscp_t                                   m_ip_dscp,
    output var ip_ecn_t                                    m_ip_ecn,
    output var ip_ttl_t                                    m_ip_ttl,
    output var ip_addr_t                                   m_ip_source_ip,
    output var ip_addr_t                                   m_ip_dest_ip,
    output var udp_port_t                                  m_source_port,
    output var udp_port_t                                  m_dest_port,
    output var udp_len_t                                   m_length,
    output var udp_len_t                                   m_checksum,

    output var logic [`UDP_DATA_W-1:0]                     m_tdata,
    output var logic [`UDP_KEEP_W-1:0]                     m_tkeep,
    output var logic                                       m_tvalid,
    input  var logic                                       m_tready,
    output var logic                                       m_tlast,

    output var logic                                       frame_done
);

    logic     locked;           // Frame in progress
    src_sel_t lock_sel;
    logic     hdr_take;
    logic     hdr_load;
    logic     pay_room;
    logic     pay_load;
    logic     pay_end;

    // Header accepted only between frames and with room in the output stage
    assign hdr_take = !locked && enable && (!m_hdr_valid || m_hdr_ready);
    assign pay_room = !m_tvalid || m_tready;

    for (genvar i = 0; i < `UDP_S_COUNT; i++) begin : g_src
        assign s_hdr_ready[i] = hdr_take && (select == src_sel_t'(i));
        assign s_tready[i]    = locked && (lock_sel == src_sel_t'(i)) && pay_room;
    end

    assign hdr_load = s_hdr_valid[select] && s_hdr_ready[select];
    assign pay_load = s_tvalid[lock_sel] && s_tready[lock_sel];
    assign pay_end  = pay_load && s_tlast[lock_sel];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            locked   <= 1'b0;
            lock_sel <= '0;
        end else if (hdr_load) begin
            locked   <= 1'b1;
            lock_sel <= select;
        end else if (pay_end) begin
            locked   <= 1'b0;       // Select is looked at again next cycle
        end
    end

    // Output header stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_hdr_valid <= 1'b0;
        end else if (hdr_load) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_load) begin
            m_ip_dscp      <= s_ip_dscp[select];
            m_ip_ecn       <= s_ip_ecn[select];
            m_ip_ttl       <= s_ip_ttl[select];
            m_ip_source_ip <= s_ip_source_ip[select];
            m_ip_dest_ip   <= s_ip_dest_ip[select];
            m_source_port  <= s_source_port[select];
            m_dest_port    <= s_dest_port[select];
            m_length       <= s_length[select];
            m_checksum     <= s_checksum[select];
        end
    end

    // Payload output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_tvalid <= 1'b0;
        end else if (pay_load) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pay_load) begin
            m_tdata <= s_tdata[lock_sel];
            m_tkeep <= s_tkeep[lock_sel];
            m_tlast <= s_tlast[lock_sel];
        end
    end

    assign frame_done = m_tvalid && m_tready && m_tlast;

    // Stalled beat holds until the sink takes it
    m_payload_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tkeep, m_tlast})
    );

    // No source drains payload between frames
    no_tready_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        !locked |-> s_tready == '0
    );

endmodule

`default_nettype wire

// ==== hdl/udp_tx_top.sv ====
// Top level of the UDP transmit mux
// Host register block driving the frame-locked multiplexer
`timescale 1ns/1ns
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx_top
    import udp_tx_pkg::*;
(
    input  var logic                                       clk,
    input  var logic                                       arst_n,

    input  var logic      [`UDP_S_COUNT-1:0]               s_hdr_valid,
    output var logic      [`UDP_S_COUNT-1:0]               s_hdr_ready,
    input  var ip_dscp_t  [`UDP_S_COUNT-1:0]               s_ip_dscp,
    input  var ip_ecn_t   [`UDP_S_COUNT-1:0]               s_ip_ecn,
    input  var ip_ttl_t   [`UDP_S_COUNT-1:0]               s_ip_ttl,
    input  var ip_addr_t  [`UDP_S_COUNT-1:0]               s_ip_source_ip,
    input  var ip_addr_t  [`UDP_S_COUNT-1:0]               s_ip_dest_ip,
    input  var udp_port_t [`UDP_S_COUNT-1:0]               s_source_port,
    input  var udp_port_t [`UDP_S_COUNT-1:0]               s_dest_port,
    input  var udp_len_t  [`UDP_S_COUNT-1:0]               s_length,
    input  var udp_len_t  [`UDP_S_COUNT-1:0]               s_checksum,

    input  var logic [`UDP_S_COUNT-1:0][`UDP_DATA_W-1:0]   s_tdata,
    input  var logic [`UDP_S_COUNT-1:0][`UDP_KEEP_W-1:0]   s_tkeep,
    input  var logic [`UDP_S_COUNT-1:0]                    s_tvalid,
    output var logic [`UDP_S_COUNT-1:0]                    s_tready,
    input  var logic [`UDP_S_COUNT-1:0]                    s_tlast,

    output var logic                                       m_hdr_valid,
    input  var logic                                       m_hdr_ready,
    output var ip_dscp_t                                   m_ip_dscp,
    output var ip_ecn_t                                    m_ip_ecn,
    output var ip_ttl_t                                    m_ip_ttl,
    output var ip_addr_t                                   m_ip_source_ip,
    output var ip_addr_t                                   m_ip_dest_ip,
    output var udp_port_t                                  m_source_port,
    output var udp_port_t                                  m_dest_port,
    output var udp_len_t                                   m_length,
    output var udp_len_t                                   m_checksum,

    output var logic [`UDP_DATA_W-1:0]                     m_tdata,
    output var logic [`UDP_KEEP_W-1:0]                     m_tkeep,
    output var logic                                       m_tvalid,
    input  var logic                                       m_tready,
    output var logic                                       m_tlast,

    input  var logic                                       wr_en,
    input  var logic [`UDP_REG_AW-1:0]                     wr_addr,
    input  var logic [`UDP_REG_DW-1:0]                     wr_data,
    input  var logic                                       rd_en,
    input  var logic [`UDP_REG_AW-1:0]                     rd_addr,
    output var logic [`UDP_REG_DW-1:0]                     rd_data,
    output var logic                                       rd_valid
);

    logic     enable;
    src_sel_t select;
    logic     frame_done;       // One pulse per forwarded frame

    udp_tx_regs i_udp_tx_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .frame_done (frame_done),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .enable     (enable),
        .select     (select)
    );

    udp_mux i_udp_mux (
        .clk            (clk),
        .arst_n         (arst_n),
        .enable         (enable),
        .select         (select),

        .s_hdr_valid    (s_hdr_valid),
        .s_hdr_ready    (s_hdr_ready),
        .s_ip_dscp      (s_ip_dscp),
        .s_ip_ecn       (s_ip_ecn),
        .s_ip_ttl       (s_ip_ttl),
        .s_ip_source_ip (s_ip_source_ip),
        .s_ip_dest_ip   (s_ip_dest_ip),
        .s_source_port  (s_source_port),
        .s_dest_port    (s_dest_port),
        .s_length       (s_length),
        .s_checksum     (s_checksum),

        .s_tdata        (s_tdata),
        .s_tkeep        (s_tkeep),
        .s_tvalid       (s_tvalid),
        .s_tready       (s_tready),
        .s_tlast        (s_tlast),

        .m_hdr_valid    (m_hdr_valid),
        .m_hdr_ready    (m_hdr_ready),
        .m_ip_dscp      (m_ip_dscp),
        .m_ip_ecn       (m_ip_ecn),
        .m_ip_ttl       (m_ip_ttl),
        .m_ip_source_ip (m_ip_source_ip),
        .m_ip_dest_ip   (m_ip_dest_ip),
        .m_source_port  (m_source_port),
        .m_dest_port    (m_dest_port),
        .m_length       (m_length),
        .m_checksum     (m_checksum),

        .m_tdata        (m_tdata),
        .m_tkeep        (m_tkeep),
        .m_tvalid       (m_tvalid),
        .m_tready       (m_tready),
        .m_tlast        (m_tlast),

        .frame_done     (frame_done)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
// Clock and reset source for the testbench
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output var logic clk,
    output var logic arst_n
);

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;             // Released right after the third edge
    end

endmodule

`default_nettype wire

// ==== testbench/udp_tx_tb.sv ====
// Random-stimulus testbench for the UDP transmit mux
// Source drivers, random sink, reference model, register checks and timeout
`timescale 1ns/1ns
`default_nettype none
`include "udp_tx_cfg.svh"

module udp_tx_tb
    import udp_tx_pkg::*;
;

    localparam int FRAMES_PER_SRC = 20;
    localparam int NUM_FRAMES     = FRAMES_PER_SRC * `UDP_S_COUNT;
    localparam int MAX_BYTES      = 32;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * MAX_BYTES * 4 + 1000;

    logic clk;
    logic arst_n;

    logic      [`UDP_S_COUNT-1:0]                   s_hdr_valid;
    logic      [`UDP_S_COUNT-1:0]                   s_hdr_ready;
    ip_dscp_t  [`UDP_S_COUNT-1:0]                   s_ip_dscp;
    ip_ecn_t   [`UDP_S_COUNT-1:0]                   s_ip_ecn;
    ip_ttl_t   [`UDP_S_COUNT-1:0]                   s_ip_ttl;
    ip_addr_t  [`UDP_S_COUNT-1:0]                   s_ip_source_ip;
    ip_addr_t  [`UDP_S_COUNT-1:0]                   s_ip_dest_ip;
    udp_port_t [`UDP_S_COUNT-1:0]                   s_source_port;
    udp_port_t [`UDP_S_COUNT-1:0]                   s_dest_port;
    udp_len_t  [`UDP_S_COUNT-1:0]                   s_length;
    udp_len_t  [`UDP_S_COUNT-1:0]                   s_checksum;
    logic      [`UDP_S_COUNT-1:0][`UDP_DATA_W-1:0]  s_tdata;
    logic      [`UDP_S_COUNT-1:0][`UDP_KEEP_W-1:0]  s_tkeep;
    logic      [`UDP_S_COUNT-1:0]                   s_tvalid;
    logic      [`UDP_S_COUNT-1:0]                   s_tready;
    logic      [`UDP_S_COUNT-1:0]                   s_tlast;

    logic      m_hdr_valid;
    logic      m_hdr_ready;
    ip_dscp_t  m_ip_dscp;
    ip_ecn_t   m_ip_ecn;
    ip_ttl_t   m_ip_ttl;
    ip_addr_t  m_ip_source_ip;
    ip_addr_t  m_ip_dest_ip;
    udp_port_t m_source_port;
    udp_port_t m_dest_port;
    udp_len_t  m_length;
    udp_len_t  m_checksum;
    logic [`UDP_DATA_W-1:0] m_tdata;
    logic [`UDP_KEEP_W-1:0] m_tkeep;
    logic      m_tvalid;
    logic      m_tready;
    logic      m_tlast;

    logic                   wr_en;
    logic [`UDP_REG_AW-1:0] wr_addr;
    logic [`UDP_REG_DW-1:0] wr_data;
    logic                   rd_en;
    logic [`UDP_REG_AW-1:0] rd_addr;
    logic [`UDP_REG_DW-1:0] rd_data;
    logic                   rd_valid;

    // Offered frames, indexed by source and frame number
    ip_dscp_t  hdr_dscp  [`UDP_S_COUNT][FRAMES_PER_SRC];
    ip_ecn_t   hdr_ecn   [`UDP_S_COUNT][FRAMES_PER_SRC];
    ip_ttl_t   hdr_ttl   [`UDP_S_COUNT][FRAMES_PER_SRC];
    ip_addr_t  hdr_src   [`UDP_S_COUNT][FRAMES_PER_SRC];
    ip_addr_t  hdr_dst   [`UDP_S_COUNT][FRAMES_PER_SRC];
    udp_port_t hdr_sport [`UDP_S_COUNT][FRAMES_PER_SRC];
    udp_port_t hdr_dport [`UDP_S_COUNT][FRAMES_PER_SRC];
    udp_len_t  hdr_len   [`UDP_S_COUNT][FRAMES_PER_SRC];
    udp_len_t  hdr_csum  [`UDP_S_COUNT][FRAMES_PER_SRC];
    int                     pay_len  [`UDP_S_COUNT][FRAMES_PER_SRC];
    logic [`UDP_DATA_W-1:0] pay_data [`UDP_S_COUNT][FRAMES_PER_SRC][MAX_BYTES];
    logic [`UDP_KEEP_W-1:0] pay_keep [`UDP_S_COUNT][FRAMES_PER_SRC][MAX_BYTES];

    int drv_phase [`UDP_S_COUNT];     // 0 gap, 1 header, 2 payload, 3 done
    int drv_frame [`UDP_S_COUNT];
    int drv_beat  [`UDP_S_COUNT];
    int drv_gap   [`UDP_S_COUNT];

    // Reference model state
    logic     mdl_en     = 1'b0;
    src_sel_t mdl_sel    = '0;
    logic     mdl_locked = 1'b0;
    src_sel_t mdl_src    = '0;
    logic     mdl_hvalid = 1'b0;        // Output header register full
    logic     mdl_tvalid = 1'b0;        // Output payload register full
    int       mdl_frame [`UDP_S_COUNT] = '{default: 0};
    int       exp_frame [$];            // Accepted frame ids, source * FRAMES_PER_SRC + index
    logic [`UDP_DATA_W+`UDP_KEEP_W:0] exp_beat [$];     // {tlast, tkeep, tdata}
    int       out_frames = 0;
    int       cycle_cnt  = 0;

    tb_clkgen i_tb_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    udp_tx_top i_udp_tx_top (
        .clk            (clk),
        .arst_n         (arst_n),
        .s_hdr_valid    (s_hdr_valid),
        .s_hdr_ready    (s_hdr_ready),
        .s_ip_dscp      (s_ip_dscp),
        .s_ip_ecn       (s_ip_ecn),
        .s_ip_ttl       (s_ip_ttl),
        .s_ip_source_ip (s_ip_source_ip),
        .s_ip_dest_ip   (s_ip_dest_ip),
        .s_source_port  (s_source_port),
        .s_dest_port    (s_dest_port),
        .s_length       (s_length),
        .s_checksum     (s_checksum),
        .s_tdata        (s_tdata),
        .s_tkeep        (s_tkeep),
        .s_tvalid       (s_tvalid),
        .s_tready       (s_tready),
        .s_tlast        (s_tlast),
        .m_hdr_valid    (m_hdr_valid),
        .m_hdr_ready    (m_hdr_ready),
        .m_ip_dscp      (m_ip_dscp),
        .m_ip_ecn       (m_ip_ecn),
        .m_ip_ttl       (m_ip_ttl),
        .m_ip_source_ip (m_ip_source_ip),
        .m_ip_dest_ip   (m_ip_dest_ip),
        .m_source_port  (m_source_port),
        .m_dest_port    (m_dest_port),
        .m_length       (m_length),
        .m_checksum     (m_checksum),
        .m_tdata        (m_tdata),
        .m_tkeep        (m_tkeep),
        .m_tvalid       (m_tvalid),
        .m_tready       (m_tready),
        .m_tlast        (m_tlast),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .rd_en          (rd_en),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic build_frames();
        for (int s = 0; s < `UDP_S_COUNT; s++) begin
            for (int f = 0; f < FRAMES_PER_SRC; f++) begin
                hdr_dscp[s][f]  = ip_dscp_t'($urandom);
                hdr_ecn[s][f]   = ip_ecn_t'($urandom);
                hdr_ttl[s][f]   = ip_ttl_t'($urandom);
                hdr_src[s][f]   = $urandom;
                hdr_dst[s][f]   = $urandom;
                hdr_sport[s][f] = udp_port_t'($urandom);
                hdr_dport[s][f] = udp_port_t'($urandom);
                hdr_len[s][f]   = udp_len_t'($urandom);
                hdr_csum[s][f]  = udp_len_t'($urandom);
                pay_len[s][f]   = $urandom_range(1, MAX_BYTES);
                for (int b = 0; b < MAX_BYTES; b++) begin
                    pay_data[s][f][b] = `UDP_DATA_W'($urandom);
                    pay_keep[s][f][b] = `UDP_KEEP_W'($urandom);
                end
            end
        end
    endtask

    task automatic offer_header(input int s);
        int f;
        f = drv_frame[s];
        s_hdr_valid[s]    <= 1'b1;
        s_ip_dscp[s]      <= hdr_dscp[s][f];
        s_ip_ecn[s]       <= hdr_ecn[s][f];
        s_ip_ttl[s]       <= hdr_ttl[s][f];
        s_ip_source_ip[s] <= hdr_src[s][f];
        s_ip_dest_ip[s]   <= hdr_dst[s][f];
        s_source_port[s]  <= hdr_sport[s][f];
        s_dest_port[s]    <= hdr_dport[s][f];
        s_length[s]       <= hdr_len[s][f];
        s_checksum[s]     <= hdr_csum[s][f];
    endtask

    task automatic offer_beat(input int s);
        int f;
        int b;
        f = drv_frame[s];
        b = drv_beat[s];
        s_tvalid[s] <= 1'b1;
        s_tdata[s]  <= pay_data[s][f][b];
        s_tkeep[s]  <= pay_keep[s][f][b];
        s_tlast[s]  <= (b == pay_len[s][f] - 1);
    endtask

    // Source drivers, one small state machine per source
    initial begin : source_drivers
        logic busy;
        s_hdr_valid    = '0;
        s_ip_dscp      = '0;
        s_ip_ecn       = '0;
        s_ip_ttl       = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip   = '0;
        s_source_port  = '0;
        s_dest_port    = '0;
        s_length       = '0;
        s_checksum     = '0;
        s_tdata        = '0;
        s_tkeep        = '0;
        s_tvalid       = '0;
        s_tlast        = '0;
        drv_phase = '{default: 0};
        drv_frame = '{default: 0};
        drv_beat  = '{default: 0};
        drv_gap   = '{default: 0};
        forever begin
            @(posedge clk);
            for (int s = 0; s < `UDP_S_COUNT; s++) begin
                busy = (drv_phase[s] == 1) || (drv_phase[s] == 2 && s_tvalid[s]);
                if (drv_phase[s] == 1 && s_hdr_ready[s]) begin
                    s_hdr_valid[s] <= 1'b0;
                    drv_phase[s] = 2;
                    drv_beat[s]  = 0;
                    drv_gap[s]   = $urandom_range(0, 2);
                    busy = 1'b0;
                end else if (drv_phase[s] == 2 && s_tvalid[s] && s_tready[s]) begin
                    s_tvalid[s] <= 1'b0;
                    drv_beat[s]++;
                    drv_gap[s] = $urandom_range(0, 2);
                    busy = 1'b0;
                    if (drv_beat[s] == pay_len[s][drv_frame[s]]) begin
                        drv_frame[s]++;
                        drv_phase[s] = (drv_frame[s] == FRAMES_PER_SRC) ? 3 : 0;
                        drv_gap[s]   = $urandom_range(0, 6);     // Idle time between frames
                    end
                end
                if (!busy && drv_phase[s] != 3) begin
                    if (drv_gap[s] > 0) begin
                        drv_gap[s]--;
                    end else if (drv_phase[s] == 0) begin
                        offer_header(s);
                        drv_phase[s] = 1;
                    end else begin
                        offer_beat(s);
                    end
                end
            end
        end
    end

    // Random back-pressure from the sink
    initial begin : sink
        m_hdr_ready = 1'b0;
        m_tready    = 1'b0;
        forever begin
            @(posedge clk);
            m_hdr_ready <= ($urandom_range(0, 3) != 0);
            m_tready    <= ($urandom_range(0, 2) != 0);
        end
    end

    task automatic record_accept(input int s);
        int f;
        f = mdl_frame[s];
        if (f >= FRAMES_PER_SRC) begin
            abort_run($sformatf("Source %0d had a header accepted after its last frame", s));
        end else begin
            exp_frame.push_back(s * FRAMES_PER_SRC + f);
            for (int b = 0; b < pay_len[s][f]; b++) begin
                exp_beat.push_back({b == pay_len[s][f] - 1, pay_keep[s][f][b], pay_data[s][f][b]});
            end
            mdl_frame[s]++;
            mdl_locked = 1'b1;
            mdl_src    = src_sel_t'(s);
        end
    endtask

    task automatic compare_header(input int fid);
        int s;
        int f;
        s = fid / FRAMES_PER_SRC;
        f = fid % FRAMES_PER_SRC;
        compare("m_ip_dscp", m_ip_dscp, hdr_dscp[s][f]);
        compare("m_ip_ecn", m_ip_ecn, hdr_ecn[s][f]);
        compare("m_ip_ttl", m_ip_ttl, hdr_ttl[s][f]);
        compare("m_ip_source_ip", m_ip_source_ip, hdr_src[s][f]);
        compare("m_ip_dest_ip", m_ip_dest_ip, hdr_dst[s][f]);
        compare("m_source_port", m_source_port, hdr_sport[s][f]);
        compare("m_dest_port", m_dest_port, hdr_dport[s][f]);
        compare("m_length", m_length, hdr_len[s][f]);
        compare("m_checksum", m_checksum, hdr_csum[s][f]);
    endtask

    // Reference model, sampling the values the DUT sees on each edge
    always @(posedge clk) begin : model
        int   fid;
        logic exp_rdy;
        logic hdr_in;
        logic beat_in;
        logic [`UDP_DATA_W+`UDP_KEEP_W:0] beat;
        if (arst_n) begin
            cycle_cnt++;
            if (cycle_cnt >= TIMEOUT_CYCLES) begin
                abort_run($sformatf("Timeout after %0d cycles, %0d of %0d frames still outstanding",
                                    cycle_cnt, NUM_FRAMES - out_frames, NUM_FRAMES));
            end
            compare("m_hdr_valid", m_hdr_valid, mdl_hvalid);
            compare("m_tvalid", m_tvalid, mdl_tvalid);
            for (int s = 0; s < `UDP_S_COUNT; s++) begin
                exp_rdy = !mdl_locked && mdl_en && mdl_sel == src_sel_t'(s)
                          && (!mdl_hvalid || m_hdr_ready);
                compare($sformatf("s_hdr_ready[%0d]", s), s_hdr_ready[s], exp_rdy);
                exp_rdy = mdl_locked && mdl_src == src_sel_t'(s) && (!mdl_tvalid || m_tready);
                compare($sformatf("s_tready[%0d]", s), s_tready[s], exp_rdy);
            end
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_frame.size() == 0) begin
                    abort_run("Output header appeared with no accepted header pending");
                end else begin
                    fid = exp_frame.pop_front();
                    compare_header(fid);
                end
            end
            if (m_tvalid && m_tready) begin
                if (exp_beat.size() == 0) begin
                    abort_run("Output payload beat appeared with no accepted payload pending");
                end else begin
                    beat = exp_beat.pop_front();
                    compare("m_tdata", m_tdata, beat[`UDP_DATA_W-1:0]);
                    compare("m_tkeep", m_tkeep, beat[`UDP_DATA_W +: `UDP_KEEP_W]);
                    compare("m_tlast", m_tlast, beat[`UDP_DATA_W+`UDP_KEEP_W]);
                    if (m_tlast) out_frames++;
                end
            end
            // Lock ends on the input tlast beat
            beat_in = mdl_locked && s_tvalid[mdl_src] && s_tready[mdl_src];
            if (beat_in && s_tlast[mdl_src])
                mdl_locked = 1'b0;
            hdr_in = 1'b0;
            for (int s = 0; s < `UDP_S_COUNT; s++) begin
                if (s_hdr_valid[s] && s_hdr_ready[s]) begin
                    record_accept(s);
                    hdr_in = 1'b1;
                end
            end
            // Output stages fill on an input transfer and drain on ready
            if (hdr_in)
                mdl_hvalid = 1'b1;
            else if (m_hdr_ready)
                mdl_hvalid = 1'b0;
            if (beat_in)
                mdl_tvalid = 1'b1;
            else if (m_tready)
                mdl_tvalid = 1'b0;
            if (wr_en && wr_addr == `UDP_REG_AW'(`UDP_REG_CTRL)) begin
                mdl_en  = wr_data[0];
                mdl_sel = wr_data[1 +: `UDP_SEL_W];
            end
        end
    end

    task automatic write_reg(input logic [`UDP_REG_AW-1:0] addr,
                             input logic [`UDP_REG_DW-1:0] data);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= addr;
        wr_data <= data;
        @(posedge clk);
        wr_en   <= 1'b0;
    endtask

    task automatic read_reg(input logic [`UDP_REG_AW-1:0] addr,
                            output logic [`UDP_REG_DW-1:0] data);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        @(posedge clk);
        rd_en   <= 1'b0;
        @(posedge clk);
        compare("rd_valid", rd_valid, 1'b1);
        data = rd_data;
    endtask

    initial begin : main
        logic [`UDP_REG_DW-1:0] rdata;
        logic [`UDP_REG_DW-1:0] ctrl;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        void'($urandom(10767));
        build_frames();
        wait (arst_n === 1'b1);
        @(posedge clk);
        compare("m_hdr_valid", m_hdr_valid, 1'b0);
        compare("m_tvalid", m_tvalid, 1'b0);
        compare("s_hdr_ready", s_hdr_ready, '0);
        compare("s_tready", s_tready, '0);
        read_reg(`UDP_REG_CTRL, rdata);
        compare("ctrl register", rdata, '0);
        read_reg(`UDP_REG_FRAMES, rdata);
        compare("frame register", rdata, '0);
        // Frame counter is read only
        write_reg(`UDP_REG_FRAMES, `UDP_REG_DW'($urandom));
        read_reg(`UDP_REG_FRAMES, rdata);
        compare("frame register after write", rdata, '0);
        ctrl    = '0;
        ctrl[1] = $urandom_range(0, 1);
        write_reg(`UDP_REG_CTRL, ctrl);
        read_reg(`UDP_REG_CTRL, rdata);
        compare("ctrl register readback", rdata, ctrl);
        // Sources keep offering while the mux is disabled
        repeat (150) begin
            @(posedge clk);
            compare("m_hdr_valid", m_hdr_valid, 1'b0);
            compare("s_hdr_ready", s_hdr_ready, '0);
        end
        while (out_frames < NUM_FRAMES || exp_frame.size() != 0) begin
            ctrl    = '0;
            ctrl[0] = ($urandom_range(0, 7) != 0);
            ctrl[1] = $urandom_range(0, 1);
            write_reg(`UDP_REG_CTRL, ctrl);
            repeat ($urandom_range(4, 24)) @(posedge clk);
        end
        read_reg(`UDP_REG_FRAMES, rdata);
        compare("frame register", rdata, `UDP_REG_DW'(out_frames));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/udp_tx_pkg.sv
hdl/udp_tx_regs.sv
hdl/udp_mux.sv
hdl/udp_tx_top.sv
testbench/tb_clkgen.sv
testbench/udp_tx_tb.sv
